// File: tests/cpu_golden.mem
# P word_addr w0 w1 w2 w3 : four program words from word_addr, all hex
# E test pc read write chk alu_result write_data : chk bit0 alu, bit1 write_data
P 00 00010005 00020003 02030102 03040201
P 04 04050104 05060102 01070003 06010000
P 08 000100ee 07020102 10010102 000100ee
P 0c 07010307 000100ee 10050307 06020000
P 10 06030000 000100ee 10fd0102 000100ee
P 14 0b000320 0a000605 09010020 08020005
P 18 01030001 01040002 0b000230 0b000531
P 1c 09060031 09070030 02010607 0c020106
P 20 01030002 06ff0000 06ff0000 06ff0000
E 1 00000000 0 0 1 05 00
E 2 00000004 0 0 1 03 00
E 2 00000008 0 0 1 08 00
E 2 0000000c 0 0 1 fe 00
E 2 00000010 0 0 1 04 00
E 2 00000014 0 0 1 07 00
E 2 00000018 0 0 1 08 00
E 3 0000001c 0 0 0 00 00
E 3 00000024 0 0 0 00 00
E 3 00000028 0 0 0 00 00
E 3 00000030 0 0 0 00 00
E 3 00000038 0 0 0 00 00
E 3 0000003c 0 0 0 00 00
E 3 00000048 0 0 0 00 00
E 3 00000040 0 0 0 00 00
E 4 00000050 0 1 3 20 08
E 4 00000054 0 1 3 04 07
E 4 00000058 1 0 1 20 00
E 4 0000005c 1 0 1 04 00
E 4 00000060 0 0 1 08 00
E 4 00000064 0 0 1 07 00
E 5 00000068 0 1 3 30 07
E 5 0000006c 0 1 3 31 04
E 5 00000070 1 0 1 31 00
E 5 00000074 1 0 1 30 00
E 5 00000078 0 0 1 0b 00
E 6 0000007c 0 0 0 00 00
E 6 00000080 0 0 1 07 00
E 6 00000084 0 0 0 00 00
E 6 00000084 0 0 0 00 00

// File: all.f
+incdir+design
design/cpu_pkg.sv
design/pc_unit.sv
design/control_unit.sv
design/reg_file.sv
design/alu.sv
design/cpu.sv
tests/cpu_checker.sv
tests/tb_cpu.sv

// File: run.sh
#!/bin/sh
# build the cpu testbench with verilator, run it and judge the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 -f all.f --top-module tb_cpu -o tb_cpu
./obj_dir/tb_cpu > sim.log 2>&1 || true
cat sim.log

if grep -q "TEST RESULT: PASS" sim.log
then
    exit 0
fi
exit 1

// File: tests/tb_cpu.sv
`timescale 1ns/1ps
`default_nettype none

`include "cpu_defs.svh"

module tb_cpu;

    localparam int          RESET_CYCLES = 16;
    localparam int          TRACE_MAX    = 64;
    localparam logic [31:0] LCG_SEED     = 32'hf292_8dfb;

    logic                 CLK;
    logic                 RESET;
    logic [31:0]          instruction;
    logic                 busywait;
    logic [`DATA_W-1:0]   read_data;
    wire  [`ADDR_W-1:0]   pc;
    wire                  read;
    wire                  write;
    wire  [`DATA_W-1:0]   write_data;
    wire  [`DATA_W-1:0]   alu_result;
    wire                  done;             // checker reached the end of the trace
    wire  [31:0]          error_count;

    logic [31:0]          imem [0:255];     // program words indexed by pc[9:2]
    logic [`DATA_W-1:0]   dmem [0:255];     // byte-wide data memory
    logic [63:0]          trace [0:TRACE_MAX-1];
    logic [31:0]          reset_word;       // memory op fed in while RESET is high
    int                   trace_len;
    int                   cycles;
    int                   limit;
    bit                   golden_ok;

    initial CLK = 1'b0;
    always #5 CLK = ~CLK;                   // 10 ns period

    assign instruction = RESET ? reset_word : imem[pc[9:2]];   // fetch follows pc

    cpu u_cpu (
        .CLK         (CLK),
        .RESET       (RESET),
        .instruction (instruction),
        .busywait    (busywait),
        .read_data   (read_data),
        .pc          (pc),
        .read        (read),
        .write       (write),
        .write_data  (write_data),
        .alu_result  (alu_result)
    );

    cpu_checker #(.TRACE_MAX(TRACE_MAX)) u_checker (
        .CLK         (CLK),
        .RESET       (RESET),
        .busywait    (busywait),
        .pc          (pc),
        .read        (read),
        .write       (write),
        .alu_result  (alu_result),
        .write_data  (write_data),
        .trace       (trace),
        .trace_len   (trace_len),
        .done        (done),
        .error_count (error_count)
    );

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    // P lines fill program words and E lines append to the expected trace
    task automatic read_golden(output bit ok);
        int          fd;
        int          n;
        string       line;
        logic [7:0]  waddr;
        logic [31:0] w0, w1, w2, w3;
        int          t, erd, ewr, echk;
        logic [31:0] epc, ealu, ewd;
        trace_len = 0;
        fd = $fopen("tests/cpu_golden.mem", "r");
        ok = (fd != 0);
        if (ok)
        begin
            while (!$feof(fd))
            begin
                n = $fgets(line, fd);
                if (n > 0 && line.getc(0) == "P")
                begin
                    n = $sscanf(line, "P %h %h %h %h %h", waddr, w0, w1, w2, w3);
                    ok = ok && (n == 5);
                    imem[waddr]        = w0;
                    imem[waddr + 8'd1] = w1;
                    imem[waddr + 8'd2] = w2;
                    imem[waddr + 8'd3] = w3;
                end
                else if (n > 0 && line.getc(0) == "E" && trace_len < TRACE_MAX)
                begin
                    n = $sscanf(line, "E %d %h %d %d %d %h %h",
                                t, epc, erd, ewr, echk, ealu, ewd);
                    ok = ok && (n == 7);
                    trace[trace_len[5:0]] = {t[7:0], epc, erd[0], ewr[0], echk[1:0],
                                             4'h0, ealu[7:0], ewd[7:0]};
                    trace_len++;
                end
            end
            $fclose(fd);
            ok = ok && (trace_len > 0);
        end
    endtask

    ////////////////////////////////////////////////////////////
    // data memory with random stall length per access
    ////////////////////////////////////////////////////////////
    initial
    begin : data_memory
        logic [31:0] lcg_state;
        logic [1:0]  stall_left;
        bit          in_access;
        busywait   = 1'b0;
        read_data  = '0;
        lcg_state  = LCG_SEED;
        stall_left = 2'd0;
        in_access  = 1'b0;
        for (int i = 0; i < 256; i++)
            dmem[i[7:0]] = i[7:0] ^ 8'h5a;      // address dependent fill
        forever
        begin
            @(posedge CLK);
            if (!RESET && !busywait)
            begin
                if (write)
                    dmem[alu_result] = write_data;  // store lands on the retiring edge
                in_access = 1'b0;
            end
            #1;
            if (RESET)
            begin
                busywait  = 1'b0;
                in_access = 1'b0;
            end
            else
            begin
                if ((read || write) && !in_access)
                begin
                    lcg_state  = lcg_next(lcg_state);
                    stall_left = lcg_state[31:30];  // 0 to 3 stall cycles
                    in_access  = 1'b1;
                end
                if (in_access && stall_left != 2'd0)
                begin
                    busywait   = 1'b1;
                    stall_left = stall_left - 2'd1;
                end
                else
                    busywait = 1'b0;
            end
            read_data = dmem[alu_result];
        end
    end

    initial
    begin
        RESET      = 1'b1;
        reset_word = {`OP_LWI, 24'h010020};    // lwi r1, 0x20
        for (int i = 0; i < 256; i++)
            imem[i[7:0]] = {24'hff0000, i[7:0]};   // unknown opcode decodes as a no-op
        read_golden(golden_ok);
        if (!golden_ok)
        begin
            $display("golden file tests/cpu_golden.mem is missing or malformed");
            $display("TEST RESULT: FAIL");
        end
        else
        begin
            limit = RESET_CYCLES + trace_len * 4 + 50;  // worst case 4 cycles per retire
            for (int i = 0; i < RESET_CYCLES; i++)
            begin
                @(posedge CLK);
                #1;
                reset_word = i[0] ? {`OP_LWI, 24'h010020}     // alternate load and store
                                  : {`OP_SWI, 24'h000120};    // swi r1, 0x20
            end
            RESET <= 1'b0;
            cycles = RESET_CYCLES;
            while (!done && cycles < limit)
            begin
                @(negedge CLK);
                cycles++;
            end
            if (done && error_count == 0)
                $display("TEST RESULT: PASS");
            else
            begin
                if (!done)
                    $display("timeout after %0d cycles, the simulation hung", cycles);
                $display("TEST RESULT: FAIL");
            end
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: tests/cpu_checker.sv
`timescale 1ns/1ps
`default_nettype none

`include "cpu_defs.svh"

module cpu_checker
#(
    parameter int TRACE_MAX = 64
)
(
    input  wire                  CLK,
    input  wire                  RESET,
    input  wire                  busywait,
    input  wire [`ADDR_W-1:0]    pc,
    input  wire                  read,
    input  wire                  write,
    input  wire [`DATA_W-1:0]    alu_result,
    input  wire [`DATA_W-1:0]    write_data,
    input  wire [63:0]           trace [0:TRACE_MAX-1],
    input  wire [31:0]           trace_len,
    output logic                 done,
    output logic [31:0]          error_count
);

    // entry layout: test 63:56, pc 55:24, read 23, write 22, check flags 21:20,
    // alu_result 15:8, write_data 7:0
    int          idx;
    int          cur_test;
    int          test_checks;
    int          test_errors;
    int          tests_seen;
    logic [63:0] e;

    task automatic expect_equal(input string what, input logic [31:0] got,
                                input logic [31:0] want);
        if (got !== want)
        begin
            $display("Fail at %0d ns: test %0d pc %h, %s is %h, expected %h",
                     $time, cur_test, pc, what, got, want);
            error_count = error_count + 32'd1;
            test_errors++;
        end
    endtask

    initial
    begin
        done        = 1'b0;
        error_count = '0;
        idx         = 0;
        cur_test    = 0;
        test_checks = 0;
        test_errors = 0;
        tests_seen  = 0;
        forever
        begin
            @(posedge CLK);
            if (RESET)
            begin
                if (read || write)              // no memory strobe in reset
                begin
                    $display("Fail at %0d ns: read or write active during reset", $time);
                    error_count = error_count + 32'd1;
                end
            end
            else if (!busywait && !done)        // one retirement per such edge
            begin
                e        = trace[idx[5:0]];
                cur_test = int'(e[63:56]);
                test_checks++;
                expect_equal("pc", pc, e[55:24]);
                expect_equal("read", {31'b0, read}, {31'b0, e[23]});
                expect_equal("write", {31'b0, write}, {31'b0, e[22]});
                if (e[20])
                    expect_equal("alu_result", {24'h0, alu_result}, {24'h0, e[15:8]});
                if (e[21])
                    expect_equal("write_data", {24'h0, write_data}, {24'h0, e[7:0]});
                idx++;
                if (idx >= trace_len || trace[idx[5:0]][63:56] != e[63:56])
                begin
                    $display("test %0d done: %0d retirements checked, %0d errors",
                             cur_test, test_checks, test_errors);
                    tests_seen++;
                    test_checks = 0;
                    test_errors = 0;
                end
                if (idx >= trace_len)
                begin
                    $display("summary: %0d tests, %0d retirements, %0d errors",
                             tests_seen, idx, error_count);
                    done = 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: design/cpu.sv
`timescale 1ns/1ps
`default_nettype none

`include "cpu_defs.svh"

module cpu
    import cpu_pkg::*;
(
    input  wire                  CLK,
    input  wire                  RESET,
    input  wire instr_t          instruction,    // fetched at pc
    input  wire                  busywait,       // data memory stall
    input  wire [`DATA_W-1:0]    read_data,
    output logic [`ADDR_W-1:0]   pc,
    output logic                 read,
    output logic                 write,
    output logic [`DATA_W-1:0]   write_data,
    output logic [`DATA_W-1:0]   alu_result      // doubles as memory address
);

    ////////////////////////////////////////////////////////////
    // control levels
    ////////////////////////////////////////////////////////////
    logic                  reg_write;
    logic                  negate;
    logic                  use_imm;
    logic [`ALU_OP_W-1:0]  alu_op;
    logic                  jump;
    logic                  branch;
    logic                  mem_to_reg;

    ////////////////////////////////////////////////////////////
    // datapath
    ////////////////////////////////////////////////////////////
    logic                  zero;
    logic [`DATA_W-1:0]    reg_out1;
    logic [`DATA_W-1:0]    reg_out2;

    assign write_data = reg_out1;           // store value comes from rs1

    control_unit u_control_unit (
        .RESET       (RESET),
        .instruction (instruction),
        .reg_write   (reg_write),
        .negate      (negate),
        .use_imm     (use_imm),
        .alu_op      (alu_op),
        .jump        (jump),
        .branch      (branch),
        .mem_to_reg  (mem_to_reg),
        .read        (read),
        .write       (write)
    );

    pc_unit u_pc_unit (
        .CLK         (CLK),
        .RESET       (RESET),
        .instruction (instruction),
        .jump        (jump),
        .branch      (branch),
        .zero        (zero),
        .busywait    (busywait),
        .pc          (pc)
    );

    reg_file u_reg_file (
        .CLK         (CLK),
        .RESET       (RESET),
        .instruction (instruction),
        .reg_write   (reg_write),
        .mem_to_reg  (mem_to_reg),
        .alu_result  (alu_result),
        .read_data   (read_data),
        .busywait    (busywait),
        .reg_out1    (reg_out1),
        .reg_out2    (reg_out2)
    );

    alu u_alu (
        .reg_out1    (reg_out1),
        .reg_out2    (reg_out2),
        .instruction (instruction),
        .negate      (negate),
        .use_imm     (use_imm),
        .alu_op      (alu_op),
        .alu_result  (alu_result),
        .zero        (zero)
    );

endmodule

`default_nettype wire

// File: design/alu.sv
`timescale 1ns/1ps
`default_nettype none

`include "cpu_defs.svh"

module alu
    import cpu_pkg::*;
(
    input  wire [`DATA_W-1:0]    reg_out1,
    input  wire [`DATA_W-1:0]    reg_out2,
    input  wire instr_t          instruction,
    input  wire                  negate,
    input  wire                  use_imm,
    input  wire [`ALU_OP_W-1:0]  alu_op,
    output logic [`DATA_W-1:0]   alu_result,
    output logic                 zero
);

    logic [`DATA_W-1:0] neg_sel;            // rs2 or its two's complement
    logic [`DATA_W-1:0] operand2;

    assign neg_sel  = negate ? (~reg_out2 + `DATA_W'd1) : reg_out2;
    assign operand2 = use_imm ? instruction.offv.imm : neg_sel;   // imm wins

    always_comb
    begin
        case (alu_op)
            `ALU_FWD: alu_result = operand2;
            `ALU_ADD: alu_result = reg_out1 + operand2;   // wraps at 8 bits
            `ALU_AND: alu_result = reg_out1 & operand2;
            `ALU_OR:  alu_result = reg_out1 | operand2;
            default:  alu_result = '0;
        endcase
    end

    assign zero = (alu_result == '0);       // feeds beq / bne

endmodule

`default_nettype wire

// File: design/reg_file.sv
`timescale 1ns/1ps
`default_nettype none

`include "cpu_defs.svh"

module reg_file
    import cpu_pkg::*;
(
    input  wire                  CLK,
    input  wire                  RESET,
    input  wire instr_t          instruction,
    input  wire                  reg_write,
    input  wire                  mem_to_reg,
    input  wire [`DATA_W-1:0]    alu_result,
    input  wire [`DATA_W-1:0]    read_data,
    input  wire                  busywait,
    output logic [`DATA_W-1:0]   reg_out1,
    output logic [`DATA_W-1:0]   reg_out2
);

    logic [`DATA_W-1:0] regs [0:`REG_CNT-1];
    logic [`DATA_W-1:0] wb_data;            // write-back value

    assign wb_data  = mem_to_reg ? read_data : alu_result;
    assign reg_out1 = regs[instruction.regv.rs1];  // async read
    assign reg_out2 = regs[instruction.regv.rs2];

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            for (int i = 0; i < `REG_CNT; i++)
                regs[i[`REG_SEL_W-1:0]] <= '0;
        end
        else if (reg_write && !busywait)     // only on the retiring edge
            regs[instruction.regv.rd] <= wb_data;
    end

    // decoder must resolve every fetched word once out of reset
    we_known: assert property (@(posedge CLK) disable iff (RESET) !$isunknown(reg_write))
        else $error("reg_write unknown, opcode %h", instruction.regv.opcode);

endmodule

`default_nettype wire

// File: design/control_unit.sv
`timescale 1ns/1ps
`default_nettype none

`include "cpu_defs.svh"

module control_unit
    import cpu_pkg::*;
(
    input  wire                   RESET,
    input  wire instr_t           instruction,
    output logic                  reg_write,
    output logic                  negate,
    output logic                  use_imm,
    output logic [`ALU_OP_W-1:0]  alu_op,
    output logic                  jump,
    output logic                  branch,
    output logic                  mem_to_reg,
    output logic                  read,
    output logic                  write
);

    ////////////////////////////////////////////////////////////
    // opcode decode
    ////////////////////////////////////////////////////////////
    always_comb
    begin
        reg_write  = 1'b0;                      // defaults are a no-op
        negate     = 1'b0;
        use_imm    = 1'b0;
        alu_op     = `ALU_FWD;
        jump       = 1'b0;
        branch     = 1'b0;
        mem_to_reg = 1'b0;
        read       = 1'b0;
        write      = 1'b0;

        case (instruction.regv.opcode)
            `OP_LOADI:
            begin
                reg_write = 1'b1;
                use_imm   = 1'b1;               // forward the immediate
            end
            `OP_MOV:
                reg_write = 1'b1;               // forward rs2
            `OP_ADD:
            begin
                reg_write = 1'b1;
                alu_op    = `ALU_ADD;
            end
            `OP_SUB:
            begin
                reg_write = 1'b1;
                alu_op    = `ALU_ADD;
                negate    = 1'b1;               // rs1 + (-rs2)
            end
            `OP_AND:
            begin
                reg_write = 1'b1;
                alu_op    = `ALU_AND;
            end
            `OP_OR:
            begin
                reg_write = 1'b1;
                alu_op    = `ALU_OR;
            end
            `OP_J:
                jump = 1'b1;
            `OP_BEQ:
            begin
                alu_op = `ALU_ADD;              // compare by subtraction
                negate = 1'b1;
                branch = 1'b1;
            end
            `OP_BNE:
            begin
                alu_op = `ALU_ADD;
                negate = 1'b1;
                branch = 1'b1;
                jump   = 1'b1;                  // branch+jump selects ~zero
            end
            `OP_LWD, `OP_LWI:
            begin
                reg_write  = 1'b1;
                use_imm    = (instruction.regv.opcode == `OP_LWI);  // address source
                mem_to_reg = 1'b1;              // write back the loaded byte
                read       = 1'b1;
            end
            `OP_SWD, `OP_SWI:
            begin
                use_imm = (instruction.regv.opcode == `OP_SWI);
                write   = 1'b1;                 // store data is rs1
            end
            default: ;                          // unknown, all inactive
        endcase

        if (RESET)
        begin
            reg_write = 1'b0;                   // nothing leaves the core in reset
            read      = 1'b0;
            write     = 1'b0;
        end
    end

    // one memory access per instruction at most
    always_comb
    begin
        rw_exclusive: assert (!(read && write))
            else $error("read and write both high, opcode %h", instruction.regv.opcode);
    end

endmodule

`default_nettype wire

// File: design/pc_unit.sv
`timescale 1ns/1ps
`default_nettype none

`include "cpu_defs.svh"

module pc_unit
    import cpu_pkg::*;
(
    input  wire                  CLK,
    input  wire                  RESET,
    input  wire instr_t          instruction,
    input  wire                  jump,
    input  wire                  branch,
    input  wire                  zero,
    input  wire                  busywait,
    output logic [`ADDR_W-1:0]   pc
);

    logic [`ADDR_W-1:0] pc_plus4;       // sequential address
    logic [`ADDR_W-1:0] offset_ext;     // offset in bytes, sign extended
    logic [`ADDR_W-1:0] target;         // branch / jump destination
    logic [`ADDR_W-1:0] next_pc;
    logic               take_target;

    assign pc_plus4   = pc + `ADDR_W'd4;
    assign offset_ext = {{(`ADDR_W-10){instruction.offv.offset[7]}},
                         instruction.offv.offset, 2'b00};   // words to bytes
    assign target     = pc_plus4 + offset_ext;              // relative to next instr

    // {branch, jump} encoding follows the decoder
    always_comb
    begin
        case ({branch, jump})
            2'b01:   take_target = 1'b1;        // j
            2'b10:   take_target = zero;        // beq
            2'b11:   take_target = ~zero;       // bne
            default: take_target = 1'b0;        // straight line
        endcase
    end

    assign next_pc = take_target ? target : pc_plus4;

    always_ff @(posedge CLK)
    begin
        if (RESET)
            pc <= '0;
        else if (!busywait)                     // hold during memory stall
            pc <= next_pc;
    end

    // offsets are scaled by 4, so alignment must survive every update
    pc_aligned: assert property (@(posedge CLK) disable iff (RESET) pc[1:0] == 2'b00)
        else $error("pc not word aligned: %h", pc);

endmodule

`default_nettype wire

// File: design/cpu_pkg.sv
`default_nettype none

`include "cpu_defs.svh"

package cpu_pkg;

    // register form: opcode | rd | rs1 | rs2, each select in the low bits of its byte
    typedef struct packed {
        logic [`OPCODE_W-1:0]        opcode;    // bits 31:24
        logic [7-`REG_SEL_W:0]       pad_rd;    // bits 23:19, unused
        logic [`REG_SEL_W-1:0]       rd;        // destination, bits 18:16
        logic [7-`REG_SEL_W:0]       pad_rs1;   // bits 15:11, unused
        logic [`REG_SEL_W-1:0]       rs1;       // first source, bits 10:8
        logic [7-`REG_SEL_W:0]       pad_rs2;   // bits 7:3, unused
        logic [`REG_SEL_W-1:0]       rs2;       // second source, bits 2:0
    } instr_regs_t;

    // offset form: branch offset sits where rd lives
    typedef struct packed {
        logic [`OPCODE_W-1:0]        opcode;    // bits 31:24
        logic [7:0]                  offset;    // word offset, signed
        logic [7:0]                  unused;    // bits 15:8
        logic [`DATA_W-1:0]          imm;       // immediate, bits 7:0
    } instr_offs_t;

    // bits 23:16 decode as rd or as branch offset depending on opcode
    typedef union packed {
        instr_regs_t                 regv;      // register view
        instr_offs_t                 offv;      // offset / immediate view
    } instr_t;

endpackage

`default_nettype wire

// File: design/cpu_defs.svh
`ifndef CPU_DEFS_SVH
`define CPU_DEFS_SVH

////////////////////////////////////////////////////////////
// widths
////////////////////////////////////////////////////////////
`define DATA_W      8           // data path and register width
`define ADDR_W      32          // program counter width
`define REG_CNT     8           // number of registers
`define REG_SEL_W   3           // register select bits
`define OPCODE_W    8           // opcode field width
`define ALU_OP_W    3           // alu function select width

////////////////////////////////////////////////////////////
// opcodes
////////////////////////////////////////////////////////////
`define OP_LOADI    8'h00       // rd <= imm
`define OP_MOV      8'h01       // rd <= rs2
`define OP_ADD      8'h02       // rd <= rs1 + rs2
`define OP_SUB      8'h03       // rd <= rs1 - rs2
`define OP_AND      8'h04       // rd <= rs1 & rs2
`define OP_OR       8'h05       // rd <= rs1 | rs2
`define OP_J        8'h06       // unconditional jump
`define OP_BEQ      8'h07       // branch when rs1 == rs2
`define OP_LWD      8'h08       // load, address in rs2
`define OP_LWI      8'h09       // load, address in imm
`define OP_SWD      8'h0a       // store rs1, address in rs2
`define OP_SWI      8'h0b       // store rs1, address in imm
`define OP_BNE      8'h10       // branch when rs1 != rs2

////////////////////////////////////////////////////////////
// alu functions
////////////////////////////////////////////////////////////
`define ALU_FWD     3'b000      // pass second operand
`define ALU_ADD     3'b001      // also sub via negate
`define ALU_AND     3'b010
`define ALU_OR      3'b011

`endif
